// ==== riscvPkg.sv ====
package riscvPkg;

	localparam int XLEN = 32;
	localparam int REG_W = 5;
	localparam int IADDR_W = 12; // Byte address into instruction memory
	localparam int DMEM_WORDS = 1024;
	localparam int DADDR_W = $clog2(DMEM_WORDS);

	typedef logic [XLEN-1:0] word;
	typedef logic [REG_W-1:0] regAddr;
	typedef logic [IADDR_W-1:0] instAddr;
	typedef logic [DADDR_W-1:0] dataAddr;
	typedef logic [XLEN/8-1:0] byteEn;

	// Major opcodes, inst[6:0]
	localparam logic [6:0] OP_LUI = 7'b0110111;
	localparam logic [6:0] OP_AUIPC = 7'b0010111;
	localparam logic [6:0] OP_JAL = 7'b1101111;
	localparam logic [6:0] OP_JALR = 7'b1100111;
	localparam logic [6:0] OP_BRANCH = 7'b1100011;
	localparam logic [6:0] OP_LOAD = 7'b0000011;
	localparam logic [6:0] OP_STORE = 7'b0100011;
	localparam logic [6:0] OP_IMM = 7'b0010011;
	localparam logic [6:0] OP_REG = 7'b0110011;
	localparam logic [6:0] OP_SYSTEM = 7'b1110011;

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
		ALU_SRL, ALU_SRA, ALU_OR, ALU_AND,
		ALU_PASSB // LUI only
	} aluOp;

	typedef enum logic [2:0] {IMM_I, IMM_S, IMM_B, IMM_U, IMM_J} immSel;

	typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_PC4} wbSel;

	typedef struct packed {
		logic regWrite;
		logic aluSrcImm; // Operand B from immediate
		logic aluSrcPc;  // Operand A from PC
		logic memWrite;
		logic memRead;
		logic memByte;   // LBU and SB
		logic isBranch;
		logic isJal;
		logic isJalr;
		logic isHalt;
		immSel immSel;
		aluOp alu;
		wbSel wb;
	} ctrl;

endpackage

// ==== alu.sv ====
`timescale 1ns/1ps

module alu import riscvPkg::*; (
	input word a,
	input word b,
	input aluOp op,
	input logic [2:0] funct3,
	output word result,
	output logic taken
);

	logic eq;
	logic lt;
	logic ltu;
	logic [4:0] shamt;

	assign eq = (a == b);
	assign lt = ($signed(a) < $signed(b));
	assign ltu = (a < b);
	assign shamt = b[4:0];

	always_comb begin
		case (op)
			ALU_SUB: result = a - b;
			ALU_SLL: result = a << shamt;
			ALU_SLT: result = word'(lt);
			ALU_SLTU: result = word'(ltu);
			ALU_XOR: result = a ^ b;
			ALU_SRL: result = a >> shamt;
			ALU_SRA: result = $signed(a) >>> shamt;
			ALU_OR: result = a | b;
			ALU_AND: result = a & b;
			ALU_PASSB: result = b;
			default: result = a + b;
		endcase
	end

	// Compare picked by op, funct3[0] flips it for BNE BGE BGEU
	always_comb begin
		case (op)
			ALU_SLT: taken = lt ^ funct3[0];
			ALU_SLTU: taken = ltu ^ funct3[0];
			default: taken = eq ^ funct3[0];
		endcase
	end

endmodule

// ==== control.sv ====
`timescale 1ns/1ps

module control import riscvPkg::*; (
	input word inst,
	output ctrl ctl
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic alt; // funct7 bit 5

	assign opcode = inst[6:0];
	assign funct3 = inst[14:12];
	assign alt = inst[30];

	function automatic aluOp arithOp(input logic [2:0] f3, input logic sub);
		case (f3)
			3'b000: arithOp = sub ? ALU_SUB : ALU_ADD;
			3'b001: arithOp = ALU_SLL;
			3'b010: arithOp = ALU_SLT;
			3'b011: arithOp = ALU_SLTU;
			3'b100: arithOp = ALU_XOR;
			3'b101: arithOp = sub ? ALU_SRA : ALU_SRL;
			3'b110: arithOp = ALU_OR;
			default: arithOp = ALU_AND;
		endcase
	endfunction

	always_comb begin
		ctl = '0; // No-op that writes nothing
		ctl.immSel = IMM_I;
		ctl.alu = ALU_ADD;
		ctl.wb = WB_ALU;
		case (opcode)
			OP_LUI: begin
				ctl.regWrite = 1'b1;
				ctl.aluSrcImm = 1'b1;
				ctl.immSel = IMM_U;
				ctl.alu = ALU_PASSB;
			end
			OP_AUIPC: begin
				ctl.regWrite = 1'b1;
				ctl.aluSrcImm = 1'b1;
				ctl.aluSrcPc = 1'b1;
				ctl.immSel = IMM_U;
			end
			OP_JAL: begin
				ctl.regWrite = 1'b1;
				ctl.isJal = 1'b1;
				ctl.immSel = IMM_J;
				ctl.wb = WB_PC4;
			end
			OP_JALR: begin
				ctl.regWrite = 1'b1;
				ctl.isJalr = 1'b1;
				ctl.aluSrcImm = 1'b1;
				ctl.wb = WB_PC4;
			end
			OP_BRANCH: begin
				ctl.isBranch = 1'b1;
				ctl.immSel = IMM_B;
				// funct3[0] is the inverted sense, applied in the ALU
				case (funct3[2:1])
					2'b10: ctl.alu = ALU_SLT;
					2'b11: ctl.alu = ALU_SLTU;
					default: ctl.alu = ALU_SUB; // BEQ and BNE
				endcase
			end
			OP_LOAD: begin
				ctl.regWrite = 1'b1;
				ctl.memRead = 1'b1;
				ctl.aluSrcImm = 1'b1;
				ctl.memByte = funct3[2]; // LBU
				ctl.wb = WB_MEM;
			end
			OP_STORE: begin
				ctl.memWrite = 1'b1;
				ctl.aluSrcImm = 1'b1;
				ctl.immSel = IMM_S;
				ctl.memByte = (funct3[1:0] == 2'b00); // SB
			end
			OP_IMM: begin
				ctl.regWrite = 1'b1;
				ctl.aluSrcImm = 1'b1;
				ctl.alu = arithOp(funct3, alt && funct3 == 3'b101); // Only SRAI uses bit 30
			end
			OP_REG: begin
				ctl.regWrite = 1'b1;
				ctl.alu = arithOp(funct3, alt);
			end
			OP_SYSTEM: ctl.isHalt = (inst[31:20] == 12'h001); // EBREAK
			default: ;
		endcase
	end

endmodule

// ==== immGen.sv ====
`timescale 1ns/1ps

module immGen import riscvPkg::*; (
	input word inst,
	input immSel sel,
	output word imm
);

	logic sign;

	assign sign = inst[31];

	always_comb begin
		case (sel)
			IMM_S: imm = {{20{sign}}, inst[31:25], inst[11:7]};
			IMM_B: imm = {{19{sign}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
			IMM_U: imm = {inst[31:12], 12'b0};
			IMM_J: imm = {{11{sign}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
			default: imm = {{20{sign}}, inst[31:20]}; // I format
		endcase
	end

endmodule

// ==== regFile.sv ====
`timescale 1ns/1ps

module regFile import riscvPkg::*; (
	input logic CLK,
	input logic RSTn,
	input regAddr ra1,
	input regAddr ra2,
	input regAddr wa,
	output word rd1,
	output word rd2,
	input logic we,
	input word wd
);

	word regs [32];

	assign rd1 = regs[ra1];
	assign rd2 = regs[ra2];

	always_ff @(posedge CLK) begin
		if (RSTn) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else if (we && wa != '0) begin // x0 stays zero
			regs[wa] <= wd;
		end
	end

	x0Zero: assert property (@(posedge CLK) disable iff (RSTn)
		(ra1 == '0 -> rd1 == '0) && (ra2 == '0 -> rd2 == '0))
		else $error("x0 read nonzero");

endmodule

// ==== dataMem.sv ====
`timescale 1ns/1ps

module dataMem import riscvPkg::*; (
	input logic CLK,
	input logic csn,
	input logic we,
	input dataAddr addr,
	input byteEn be,
	input word din,
	output word dout
);

	word mem [DMEM_WORDS];

	assign dout = mem[addr];

	// Only enabled byte lanes change
	always_ff @(posedge CLK) begin
		if (!csn && we) begin
			for (int i = 0; i < 4; i++) begin
				if (be[i])
					mem[addr][8*i +: 8] <= din[8*i +: 8];
			end
		end
	end

endmodule

// ==== riscvCore.sv ====
`timescale 1ns/1ps

module riscvCore import riscvPkg::*; (
	input logic CLK,
	input logic RSTn,

	output logic instCsn,
	output riscvPkg::instAddr instAddr,
	input word instData,

	output logic dataCsn,
	output logic dataWe,
	output riscvPkg::dataAddr dataAddr,
	output byteEn dataBe,
	output word dataOut,
	input word dataIn,

	output regAddr rfRa1,
	output regAddr rfRa2,
	output regAddr rfWa,
	input word rfRd1,
	input word rfRd2,
	output logic rfWe,
	output word rfWd,

	output logic halt,
	output word numInst,
	output word outputPort
);

	ctrl ctl;
	word imm;
	word aluA;
	word aluB;
	word aluResult;
	logic taken;
	logic halted;
	word loadData;
	logic [7:0] loadByte;
	logic [IADDR_W-1:0] pcPlus4;
	logic [IADDR_W-1:0] pcTarget;
	logic [IADDR_W-1:0] nextPc;

	control uControl (.inst(instData), .ctl(ctl));

	immGen uImmGen (.inst(instData), .sel(ctl.immSel), .imm(imm));

	assign aluA = ctl.aluSrcPc ? word'(instAddr) : rfRd1; // AUIPC
	assign aluB = ctl.aluSrcImm ? imm : rfRd2;

	alu uAlu (
		.a(aluA),
		.b(aluB),
		.op(ctl.alu),
		.funct3(instData[14:12]),
		.result(aluResult),
		.taken(taken)
	);

	assign halt = halted | ctl.isHalt;
	assign instCsn = halted;

	assign rfRa1 = instData[19:15];
	assign rfRa2 = instData[24:20];
	assign rfWa = instData[11:7];
	assign rfWe = ctl.regWrite & ~halt;

	// Data side, word address from the ALU sum
	assign dataCsn = ~(ctl.memRead | ctl.memWrite) | halt;
	assign dataWe = ctl.memWrite & ~halt;
	assign dataAddr = aluResult[11:2];
	assign dataBe = ctl.memByte ? byteEn'(4'b0001 << aluResult[1:0]) : 4'b1111;
	assign dataOut = ctl.memByte ? {4{rfRd2[7:0]}} : rfRd2; // Byte copied to every lane

	assign loadByte = dataIn[8*aluResult[1:0] +: 8];
	assign loadData = ctl.memByte ? word'(loadByte) : dataIn;

	assign pcPlus4 = instAddr + 12'd4;
	assign pcTarget = instAddr + imm[IADDR_W-1:0];

	always_comb begin
		if (ctl.isJalr)
			nextPc = aluResult[IADDR_W-1:0] & ~12'h001;
		else if (ctl.isJal || (ctl.isBranch && taken))
			nextPc = pcTarget;
		else
			nextPc = pcPlus4;
	end

	always_comb begin
		case (ctl.wb)
			WB_MEM: rfWd = loadData;
			WB_PC4: rfWd = word'(pcPlus4); // Link address
			default: rfWd = aluResult;
		endcase
	end

	assign outputPort = rfWd;

	always_ff @(posedge CLK) begin
		if (RSTn) begin
			instAddr <= '0;
			halted <= 1'b0;
			numInst <= '0;
		end else begin
			halted <= halt; // Sticky once EBREAK is seen
			if (!halt) begin
				instAddr <= nextPc;
				numInst <= numInst + 1;
			end
		end
	end

	pcAligned: assert property (@(posedge CLK) disable iff (RSTn) instAddr[1:0] == 2'b00)
		else $error("PC not word aligned");

	// Nothing may be written once the core has stopped
	haltFreeze: assert property (@(posedge CLK) disable iff (RSTn)
		halt |=> halt && !rfWe && !dataWe)
		else $error("Write after halt");

endmodule

// ==== riscvSystem.sv ====
`timescale 1ns/1ps

module riscvSystem import riscvPkg::*; (
	input logic CLK,
	input logic RSTn,
	output logic instCsn,
	output riscvPkg::instAddr instAddr,
	input word instData,
	output logic halt,
	output word numInst,
	output word outputPort
);

	logic dmCsn;
	logic dmWe;
	dataAddr dmAddr;
	byteEn dmBe;
	word dmWdata;
	word dmRdata;

	regAddr rfRa1;
	regAddr rfRa2;
	regAddr rfWa;
	word rfRd1;
	word rfRd2;
	logic rfWe;
	word rfWd;

	riscvCore uCore (
		.CLK(CLK),
		.RSTn(RSTn),
		.instCsn(instCsn),
		.instAddr(instAddr),
		.instData(instData),
		.dataCsn(dmCsn),
		.dataWe(dmWe),
		.dataAddr(dmAddr),
		.dataBe(dmBe),
		.dataOut(dmWdata),
		.dataIn(dmRdata),
		.rfRa1(rfRa1),
		.rfRa2(rfRa2),
		.rfWa(rfWa),
		.rfRd1(rfRd1),
		.rfRd2(rfRd2),
		.rfWe(rfWe),
		.rfWd(rfWd),
		.halt(halt),
		.numInst(numInst),
		.outputPort(outputPort)
	);

	regFile uRegFile (
		.CLK(CLK),
		.RSTn(RSTn),
		.ra1(rfRa1),
		.ra2(rfRa2),
		.wa(rfWa),
		.rd1(rfRd1),
		.rd2(rfRd2),
		.we(rfWe),
		.wd(rfWd)
	);

	dataMem uDataMem (
		.CLK(CLK),
		.csn(dmCsn),
		.we(dmWe),
		.addr(dmAddr),
		.be(dmBe),
		.din(dmWdata),
		.dout(dmRdata)
	);

endmodule

// ==== tbRiscv.sv ====
`timescale 1ns/1ps

module tbRiscv import riscvPkg::*; ();

	localparam int PERIOD = 100;
	localparam int RESET_CYCLES = 8;
	localparam int MAX_CYCLES = 300; // Forward-only program of 256 words plus the halt window
	localparam int PROG_WORDS = 256;

	typedef enum logic [3:0] {
		K_OP, K_IMM, K_LUI, K_AUIPC, K_LW, K_LBU, K_SW, K_SB, K_BR, K_JAL, K_JALR, K_HALT
	} instKind;

	bit CLK;
	logic RSTn;
	word instData;
	instAddr fetchAddr;
	logic instCsn;
	logic halt;
	word numInst;
	word outputPort;

	integer seed = 37;
	int n;
	int checks;
	int errors;

	// Program image and the fields each word was built from
	word prog [PROG_WORDS];
	instKind kindF [PROG_WORDS];
	logic [2:0] f3F [PROG_WORDS];
	logic altF [PROG_WORDS];
	regAddr rdF [PROG_WORDS];
	regAddr rs1F [PROG_WORDS];
	regAddr rs2F [PROG_WORDS];
	word immF [PROG_WORDS];

	// Reference model state
	word mRegs [32] = '{default: '0};
	word mMem [DMEM_WORDS];
	instAddr mPc;
	word mCount;
	bit mHalted;

	riscvSystem uut (
		.CLK(CLK),
		.RSTn(RSTn),
		.instCsn(instCsn),
		.instAddr(fetchAddr),
		.instData(instData),
		.halt(halt),
		.numInst(numInst),
		.outputPort(outputPort)
	);

	assign instData = prog[fetchAddr[9:2]]; // Instruction memory answers in the same cycle

	initial begin
		forever #(PERIOD / 2) CLK = ~CLK;
	end

	function automatic int pick(input int range);
		return {$random(seed)} % range;
	endfunction

	function automatic word arith(input logic [2:0] f3, input logic alt, input word a, input word b);
		case (f3)
			3'b000: return alt ? a - b : a + b;
			3'b001: return a << b[4:0];
			3'b010: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'b011: return (a < b) ? 32'd1 : 32'd0;
			3'b100: return a ^ b;
			3'b101: begin
				if (alt)
					return $signed(a) >>> b[4:0];
				else
					return a >> b[4:0];
			end
			3'b110: return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic logic branchTaken(input logic [2:0] f3, input word a, input word b);
		case (f3)
			3'b000: return a == b;
			3'b001: return a != b;
			3'b100: return $signed(a) < $signed(b);
			3'b101: return $signed(a) >= $signed(b);
			3'b110: return a < b;
			default: return a >= b;
		endcase
	endfunction

	task automatic emit(input instKind k, input logic [2:0] f3, input logic alt, input regAddr rd,
		input regAddr rs1, input regAddr rs2, input word imm);
		word ins;
		case (k)
			K_OP: ins = {1'b0, alt, 5'b0, rs2, rs1, f3, rd, OP_REG};
			K_IMM: ins = {imm[11:0], rs1, f3, rd, OP_IMM};
			K_LUI: ins = {imm[31:12], rd, OP_LUI};
			K_AUIPC: ins = {imm[31:12], rd, OP_AUIPC};
			K_LW, K_LBU: ins = {imm[11:0], rs1, f3, rd, OP_LOAD};
			K_SW, K_SB: ins = {imm[11:5], rs2, rs1, f3, imm[4:0], OP_STORE};
			K_BR: ins = {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OP_BRANCH};
			K_JAL: ins = {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
			K_JALR: ins = {imm[11:0], rs1, 3'b000, rd, OP_JALR};
			default: ins = 32'h00100073; // EBREAK
		endcase
		prog[n] = ins;
		kindF[n] = k;
		f3F[n] = f3;
		altF[n] = alt;
		rdF[n] = rd;
		rs1F[n] = rs1;
		rs2F[n] = rs2;
		immF[n] = imm;
		n++;
	endtask

	task automatic buildProgram();
		logic [31:0] r;
		logic [2:0] f3;
		logic alt;
		regAddr rd;
		regAddr rs1;
		regAddr rs2;
		int lim;
		int tgt;
		n = 0;
		emit(K_IMM, 3'b000, 1'b0, 5'd1, 5'd0, 5'd0, 32'd64); // x1 is the data base, never rewritten
		for (int k = 0; k < 16; k++) begin
			r = $random(seed);
			emit(K_LUI, 3'b000, 1'b0, 5'd2, 5'd0, 5'd0, {r[31:12], 12'b0});
			emit(K_IMM, 3'b000, 1'b0, 5'd2, 5'd2, 5'd0, {{20{r[11]}}, r[11:0]});
			emit(K_SW, 3'b010, 1'b0, 5'd0, 5'd1, 5'd2, word'(4 * k - 32));
		end
		while (n < PROG_WORDS - 1) begin
			r = $random(seed);
			rd = regAddr'(pick(32));
			if (rd == 5'd1)
				rd = 5'd0; // Also exercises writes to x0
			rs1 = regAddr'(pick(32));
			rs2 = regAddr'(pick(32));
			f3 = r[14:12];
			alt = 1'b0;
			lim = (PROG_WORDS - 1 - n < 8) ? PROG_WORDS - 1 - n : 8;
			tgt = n + 1 + pick(lim); // Forward only, EBREAK at most
			case (pick(11))
				0: emit(K_OP, f3, (f3 == 3'b000 || f3 == 3'b101) && r[31], rd, rs1, rs2, '0);
				1: begin
					alt = (f3 == 3'b101) && r[31];
					if (f3 == 3'b001 || f3 == 3'b101)
						emit(K_IMM, f3, alt, rd, rs1, 5'd0, {21'b0, alt, 5'b0, r[4:0]});
					else
						emit(K_IMM, f3, alt, rd, rs1, 5'd0, {{20{r[11]}}, r[11:0]});
				end
				2: emit(K_LUI, 3'b000, 1'b0, rd, 5'd0, 5'd0, {r[31:12], 12'b0});
				3: emit(K_AUIPC, 3'b000, 1'b0, rd, 5'd0, 5'd0, {r[31:12], 12'b0});
				4: emit(K_LW, 3'b010, 1'b0, rd, 5'd1, 5'd0, word'(4 * pick(16) - 32));
				5: emit(K_LBU, 3'b100, 1'b0, rd, 5'd1, 5'd0, word'(pick(64) - 32));
				6: emit(K_SW, 3'b010, 1'b0, 5'd0, 5'd1, rs2, word'(4 * pick(16) - 32));
				7: emit(K_SB, 3'b000, 1'b0, 5'd0, 5'd1, rs2, word'(pick(64) - 32));
				8: begin
					f3 = 3'(pick(6));
					if (f3 >= 3'd2)
						f3 = f3 + 3'd2; // Skip the two unused encodings
					emit(K_BR, f3, 1'b0, 5'd0, rs1, rs2, word'(4 * (tgt - n)));
				end
				9: emit(K_JAL, 3'b000, 1'b0, rd, 5'd0, 5'd0, word'(4 * (tgt - n)));
				default: emit(K_JALR, 3'b000, 1'b0, rd, 5'd0, 5'd0, word'(4 * tgt) | word'(r[0]));
			endcase
		end
		emit(K_HALT, 3'b000, 1'b0, 5'd0, 5'd0, 5'd0, '0);
	endtask

	task automatic checkEq(input word got, input word exp, input string what);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("[FAIL] %0t ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	// One model instruction per cycle, checked mid-cycle while the DUT is settled
	task automatic stepModel();
		int i;
		word a;
		word b;
		word val;
		word addr;
		logic wr;
		instAddr next;
		i = int'(mPc[9:2]);
		a = mRegs[rs1F[i]];
		b = mRegs[rs2F[i]];
		addr = a + immF[i];
		val = '0;
		wr = 1'b1;
		next = mPc + 12'd4;
		checkEq(word'(fetchAddr), word'(mPc), "instAddr");
		checkEq(numInst, mCount, "numInst");
		checkEq(word'(halt), word'(mHalted || kindF[i] == K_HALT), "halt");
		checkEq(word'(instCsn), word'(mHalted), "instCsn");
		if (mHalted)
			return;
		case (kindF[i])
			K_OP: val = arith(f3F[i], altF[i], a, b);
			K_IMM: val = arith(f3F[i], altF[i], a, immF[i]);
			K_LUI: val = immF[i];
			K_AUIPC: val = word'(mPc) + immF[i];
			K_LW: val = mMem[addr[11:2]];
			K_LBU: val = word'(mMem[addr[11:2]][8 * addr[1:0] +: 8]);
			K_SW: begin
				wr = 1'b0;
				mMem[addr[11:2]] = b;
			end
			K_SB: begin
				wr = 1'b0;
				mMem[addr[11:2]][8 * addr[1:0] +: 8] = b[7:0];
			end
			K_BR: begin
				wr = 1'b0;
				if (branchTaken(f3F[i], a, b))
					next = mPc + immF[i][11:0];
			end
			K_JAL: begin
				val = word'(mPc) + 32'd4;
				next = mPc + immF[i][11:0];
			end
			K_JALR: begin
				val = word'(mPc) + 32'd4;
				next = instAddr'((a + immF[i]) & ~32'd1);
			end
			default: begin
				wr = 1'b0;
				mHalted = 1'b1;
			end
		endcase
		if (wr) begin
			checkEq(outputPort, val, "outputPort");
			if (rdF[i] != 5'd0)
				mRegs[rdF[i]] = val;
		end
		if (!mHalted) begin
			mPc = next;
			mCount++;
		end
	endtask

	always @(negedge CLK) begin
		if (RSTn) begin
			checkEq(word'(fetchAddr), '0, "instAddr in reset");
			checkEq(word'(halt), '0, "halt in reset");
			checkEq(numInst, '0, "numInst in reset");
		end else begin
			stepModel();
		end
	end

	initial begin
		RSTn = 1'b1;
		mPc = '0;
		mCount = '0;
		buildProgram();
		repeat (RESET_CYCLES) @(posedge CLK);
		RSTn <= 1'b0;
		wait (mHalted);
		repeat (11) @(posedge CLK); // Ten more checked cycles with the core stopped
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

	initial begin
		#(PERIOD * (MAX_CYCLES + RESET_CYCLES));
		$display("Timeout: the program never halted within %0d cycles", MAX_CYCLES);
		$display("Result: FAILED");
		$finish;
	end

endmodule

// ==== all.f ====
riscvPkg.sv
alu.sv
control.sv
immGen.sv
regFile.sv
dataMem.sv
riscvCore.sv
riscvSystem.sv
tbRiscv.sv
